// File: include/rv_pipe_settings.svh
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// data path and pc width
`define XLEN       64
`define INSTR_LEN  32
// register file shape
`define REG_IDX_W  5
`define REG_COUNT  32
// pc of the first accepted instruction
`define RESET_PC   64'h8000_0000
// supported major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

`endif

// File: src/rv_pipe_pkg.sv
`include "rv_pipe_settings.svh"

package rv_pipe_pkg;

  // one register value or pc
  typedef logic [`XLEN-1:0] xlen_t;
  // register index
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  // raw instruction word
  typedef logic [`INSTR_LEN-1:0] instr_t;

  // register-register field layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fields_t;

  // register-immediate field layout
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // same word, read either way
  typedef union packed {
    instr_t    raw;
    r_fields_t r_view;
    i_fields_t i_view;
  } instr_u;

  // alu function select
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

endpackage

// File: src/pipe_ifs.sv
`timescale 1ns/1ns

// decoded slot, decode to execute
interface id_ex_if;
  import rv_pipe_pkg::*;

  // valid low means bubble
  logic     valid;
  xlen_t    pc;
  instr_t   instr;
  alu_op_e  alu_op;
  xlen_t    rs1_val;
  xlen_t    rs2_val;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    imm;
  logic     use_imm;
  reg_idx_t rd;
  logic     wen;

  modport from_id (output valid, pc, instr, alu_op, rs1_val, rs2_val,
                   output rs1_idx, rs2_idx, imm, use_imm, rd, wen);
  modport to_ex (input valid, pc, instr, alu_op, rs1_val, rs2_val,
                 input rs1_idx, rs2_idx, imm, use_imm, rd, wen);
endinterface

// retire register contents
interface retire_if;
  import rv_pipe_pkg::*;

  logic     valid;
  xlen_t    pc;
  instr_t   instr;
  reg_idx_t rd;
  logic     wen;
  xlen_t    data;

  modport from_ex (output valid, pc, instr, rd, wen, data);
  // decode only needs the write port part
  modport to_id (input valid, rd, wen, data);
endinterface

// File: src/reg_file.sv
`timescale 1ns/1ns
`include "rv_pipe_settings.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst_i,
  input  rv_pipe_pkg::reg_idx_t rd_idx_a_i,
  input  rv_pipe_pkg::reg_idx_t rd_idx_b_i,
  output rv_pipe_pkg::xlen_t    rd_data_a_o,
  output rv_pipe_pkg::xlen_t    rd_data_b_o,
  input  logic                  wr_en_i,
  input  rv_pipe_pkg::reg_idx_t wr_idx_i,
  input  rv_pipe_pkg::xlen_t    wr_data_i,
  output rv_pipe_pkg::xlen_t    reg_a0_o
);
  import rv_pipe_pkg::*;

  xlen_t regs [`REG_COUNT];

  // x0 never written, so it stays at its reset zero
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // write-through covers the distance-2 dependency
  assign rd_data_a_o = (wr_en_i && wr_idx_i != '0 && wr_idx_i == rd_idx_a_i) ?
                       wr_data_i : regs[rd_idx_a_i];
  assign rd_data_b_o = (wr_en_i && wr_idx_i != '0 && wr_idx_i == rd_idx_b_i) ?
                       wr_data_i : regs[rd_idx_b_i];

  // x10 tap, registered value only
  assign reg_a0_o = regs[10];

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ns
`include "rv_pipe_settings.svh"

module decode_stage (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                instr_valid_i,
  input  rv_pipe_pkg::instr_t instr_i,
  id_ex_if.from_id            id_ex,
  retire_if.to_id             retire,
  output rv_pipe_pkg::xlen_t  reg_a0_o
);
  import rv_pipe_pkg::*;

  xlen_t    pc_q;
  logic     id_valid_q;
  xlen_t    id_pc_q;
  instr_u   id_instr_q;
  logic     is_op;
  logic     is_op_imm;
  logic     alt_fn;
  alu_op_e  alu_op;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    rs1_val;
  xlen_t    rs2_val;

  // pc counter and id valid
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q       <= `RESET_PC;
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= instr_valid_i;
      if (instr_valid_i) pc_q <= pc_q + xlen_t'(4);
    end
  end

  // id payload, only on accept
  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      id_pc_q        <= pc_q;
      id_instr_q.raw <= instr_i;
    end
  end

  assign is_op     = (id_instr_q.r_view.opcode == `OPC_OP);
  assign is_op_imm = (id_instr_q.i_view.opcode == `OPC_OP_IMM);
  // funct7 bit 5 for OP, imm bit 10 only for srai
  assign alt_fn = is_op ? id_instr_q.r_view.funct7[5] :
                  (id_instr_q.i_view.funct3 == 3'b101) & id_instr_q.i_view.imm12[10];

  always_comb begin
    case (id_instr_q.i_view.funct3)
      3'b000:  alu_op = alt_fn ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = alt_fn ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  assign rs1_idx = id_instr_q.r_view.rs1;
  assign rs2_idx = id_instr_q.r_view.rs2;

  // write port comes straight from the retire register
  reg_file u_reg_file (
    .clk         (clk),
    .rst_i       (rst_i),
    .rd_idx_a_i  (rs1_idx),
    .rd_idx_b_i  (rs2_idx),
    .rd_data_a_o (rs1_val),
    .rd_data_b_o (rs2_val),
    .wr_en_i     (retire.valid & retire.wen),
    .wr_idx_i    (retire.rd),
    .wr_data_i   (retire.data),
    .reg_a0_o    (reg_a0_o)
  );

  assign id_ex.valid   = id_valid_q;
  assign id_ex.pc      = id_pc_q;
  assign id_ex.instr   = id_instr_q.raw;
  assign id_ex.alu_op  = alu_op;
  assign id_ex.rs1_val = rs1_val;
  assign id_ex.rs2_val = rs2_val;
  assign id_ex.rs1_idx = rs1_idx;
  assign id_ex.rs2_idx = rs2_idx;
  // sign extended 12 bit immediate
  assign id_ex.imm     = {{(`XLEN-12){id_instr_q.i_view.imm12[11]}}, id_instr_q.i_view.imm12};
  assign id_ex.use_imm = is_op_imm;
  assign id_ex.rd      = id_instr_q.i_view.rd;
  // unsupported opcodes never write
  assign id_ex.wen     = is_op | is_op_imm;

endmodule

// File: src/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
  input logic       clk,
  input logic       rst_i,
  id_ex_if.to_ex    id_ex,
  retire_if.from_ex retire
);
  import rv_pipe_pkg::*;

  logic     ex_valid_q;
  xlen_t    ex_pc_q;
  instr_t   ex_instr_q;
  alu_op_e  ex_alu_op_q;
  xlen_t    ex_rs1_val_q;
  xlen_t    ex_rs2_val_q;
  reg_idx_t ex_rs1_idx_q;
  reg_idx_t ex_rs2_idx_q;
  xlen_t    ex_imm_q;
  logic     ex_use_imm_q;
  reg_idx_t ex_rd_q;
  logic     ex_wen_q;
  logic     ret_valid_q;
  xlen_t    ret_pc_q;
  instr_t   ret_instr_q;
  reg_idx_t ret_rd_q;
  logic     ret_wen_q;
  xlen_t    ret_data_q;
  logic     fwd_ok;
  xlen_t    op_a;
  xlen_t    src_b;
  xlen_t    op_b;
  logic [5:0] shamt;
  xlen_t    alu_res;

  // ex register
  always_ff @(posedge clk) begin
    if (rst_i) ex_valid_q <= 1'b0;
    else ex_valid_q <= id_ex.valid;
  end

  always_ff @(posedge clk) begin
    if (id_ex.valid) begin
      ex_pc_q      <= id_ex.pc;
      ex_instr_q   <= id_ex.instr;
      ex_alu_op_q  <= id_ex.alu_op;
      ex_rs1_val_q <= id_ex.rs1_val;
      ex_rs2_val_q <= id_ex.rs2_val;
      ex_rs1_idx_q <= id_ex.rs1_idx;
      ex_rs2_idx_q <= id_ex.rs2_idx;
      ex_imm_q     <= id_ex.imm;
      ex_use_imm_q <= id_ex.use_imm;
      ex_rd_q      <= id_ex.rd;
      ex_wen_q     <= id_ex.wen;
    end
  end

  // retire slot can forward when it really writes
  assign fwd_ok = ret_valid_q & ret_wen_q & (ret_rd_q != '0);
  assign op_a   = (fwd_ok && ret_rd_q == ex_rs1_idx_q) ? ret_data_q : ex_rs1_val_q;
  assign src_b  = (fwd_ok && ret_rd_q == ex_rs2_idx_q) ? ret_data_q : ex_rs2_val_q;
  assign op_b   = ex_use_imm_q ? ex_imm_q : src_b;
  // rv64 shifts, 6 bit amount
  assign shamt  = op_b[5:0];

  always_comb begin
    case (ex_alu_op_q)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_res = xlen_t'(op_a < op_b);
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_res = op_a | op_b;
      default:  alu_res = op_a & op_b;
    endcase
  end

  // retire register
  always_ff @(posedge clk) begin
    if (rst_i) ret_valid_q <= 1'b0;
    else ret_valid_q <= ex_valid_q;
  end

  always_ff @(posedge clk) begin
    if (ex_valid_q) begin
      ret_pc_q    <= ex_pc_q;
      ret_instr_q <= ex_instr_q;
      ret_rd_q    <= ex_rd_q;
      ret_wen_q   <= ex_wen_q;
      ret_data_q  <= alu_res;
    end
  end

  assign retire.valid = ret_valid_q;
  assign retire.pc    = ret_pc_q;
  assign retire.instr = ret_instr_q;
  assign retire.rd    = ret_rd_q;
  assign retire.wen   = ret_wen_q;
  assign retire.data  = ret_data_q;

endmodule

// File: src/rv_pipe_top.sv
`timescale 1ns/1ns

module rv_pipe_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  rv_pipe_pkg::instr_t   instr_i,
  output logic                  retire_valid_o,
  output rv_pipe_pkg::xlen_t    retire_pc_o,
  output rv_pipe_pkg::instr_t   retire_instr_o,
  output rv_pipe_pkg::reg_idx_t retire_rd_o,
  output logic                  retire_wen_o,
  output rv_pipe_pkg::xlen_t    retire_data_o,
  output rv_pipe_pkg::xlen_t    reg_a0_o
);

  id_ex_if  id_ex_bus ();
  retire_if retire_bus ();

  // decode owns pc, id register and the register file
  decode_stage u_decode (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .id_ex         (id_ex_bus.from_id),
    .retire        (retire_bus.to_id),
    .reg_a0_o      (reg_a0_o)
  );

  // ex register, alu, retire register
  exec_stage u_exec (
    .clk    (clk),
    .rst_i  (rst_i),
    .id_ex  (id_ex_bus.to_ex),
    .retire (retire_bus.from_ex)
  );

  // difftest style retire view
  assign retire_valid_o = retire_bus.valid;
  assign retire_pc_o    = retire_bus.pc;
  assign retire_instr_o = retire_bus.instr;
  assign retire_rd_o    = retire_bus.rd;
  assign retire_wen_o   = retire_bus.wen;
  assign retire_data_o  = retire_bus.data;

endmodule

// File: test/tb_rv_pipe.sv
`timescale 1ns/1ns
`include "rv_pipe_settings.svh"

module tb_rv_pipe;
  import rv_pipe_pkg::*;

  localparam int NUM_INSTR = 400;
  // twice the ideal run time in ns
  localparam int WATCHDOG_NS = (NUM_INSTR + 16 + 10) * 10 * 2;

  // one expected retire, due is the negedge time it must show up
  typedef struct packed {
    xlen_t                 pc;
    logic [`INSTR_LEN-1:0] instr;
    logic [`REG_IDX_W-1:0] rd;
    logic                  wen;
    xlen_t                 data;
    logic [63:0]           due;
  } retire_rec_t;

  logic                  clk;
  logic                  rst_i;
  logic                  instr_valid_i;
  logic [`INSTR_LEN-1:0] instr_i;
  logic                  retire_valid_o;
  xlen_t                 retire_pc_o;
  logic [`INSTR_LEN-1:0] retire_instr_o;
  logic [`REG_IDX_W-1:0] retire_rd_o;
  logic                  retire_wen_o;
  xlen_t                 retire_data_o;
  xlen_t                 reg_a0_o;
  // architectural model, updated in program order at issue
  xlen_t                 model_regs [`REG_COUNT];
  retire_rec_t           exp_q [$];
  retire_rec_t           head;
  // a0 as of the last checked retire
  xlen_t                 a0_committed;
  xlen_t                 issue_pc;

  rv_pipe_top DUT (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wen_o   (retire_wen_o),
    .retire_data_o  (retire_data_o),
    .reg_a0_o       (reg_a0_o)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input xlen_t exp_val, input xlen_t act_val);
    stop_run($sformatf("mismatch %s expected %h actual %h", test, exp_val, act_val));
  endtask

  // x0..x3 and x10, so hazards and x0 writes come up often
  function automatic logic [`REG_IDX_W-1:0] pick_reg();
    int unsigned r;
    r = $urandom_range(0, 4);
    return (r == 4) ? 5'd10 : r[`REG_IDX_W-1:0];
  endfunction

  // rv64i integer semantics, alt is the sub / sra bit
  function automatic xlen_t golden_result(input logic [2:0] f3, input logic alt,
                                          input xlen_t a, input xlen_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
      3'd3: return (a < b) ? xlen_t'(1) : xlen_t'(0);
      3'd4: return a ^ b;
      3'd5: return alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // builds one word, runs it on the model, queues the retire and drives it
  task automatic issue_random();
    int unsigned           kind;
    int unsigned           rnd;
    logic [2:0]            f3;
    logic                  alt;
    logic [11:0]           imm12;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [6:0]            opc;
    retire_rec_t           rec;
    kind = $urandom_range(0, 99);
    rnd  = $urandom;
    f3   = rnd[2:0];
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    rec.wen  = 1'b1;
    rec.data = '0;
    if (kind < 5) begin
      // load, store, branch or lui, never writes here
      case (rnd[23:22])
        2'd0: opc = 7'b0000011;
        2'd1: opc = 7'b0100011;
        2'd2: opc = 7'b1100011;
        default: opc = 7'b0110111;
      endcase
      rec.instr = {rnd[30:24], rs2, rs1, f3, rd, opc};
      rec.wen   = 1'b0;
    end else if (kind < 52) begin
      alt = rnd[3] && (f3 == 3'd0 || f3 == 3'd5);
      rec.instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
      rec.data  = golden_result(f3, alt, model_regs[rs1], model_regs[rs2]);
    end else begin
      // only srai has the alt bit
      alt   = rnd[3] && (f3 == 3'd5);
      imm12 = rnd[15:4];
      if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt, 4'b0, rnd[21:16]};
      rec.instr = {imm12, rs1, f3, rd, `OPC_OP_IMM};
      rec.data  = golden_result(f3, alt, model_regs[rs1], {{(`XLEN-12){imm12[11]}}, imm12});
    end
    if (rec.wen && rd != '0) model_regs[rd] = rec.data;
    rec.pc  = issue_pc;
    rec.rd  = rd;
    // sampled next edge, retire two edges later, checked at the negedge after
    rec.due = $time + 35;
    exp_q.push_back(rec);
    issue_pc = issue_pc + 4;
    instr_valid_i <= 1'b1;
    instr_i       <= rec.instr;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run("watchdog expired before all instructions retired");
  end

  // retire checks at the falling edge, outputs are settled there
  always @(negedge clk) begin
    if (!rst_i) begin
      assert (reg_a0_o == a0_committed)
        else report_mismatch("a0_tap", a0_committed, reg_a0_o);
      if (retire_valid_o) begin
        assert (exp_q.size() != 0)
          else stop_run("retire_valid_o went high with no instruction pending");
        head = exp_q.pop_front();
        assert ($time == head.due) else report_mismatch("retire_cycle", head.due, $time);
        assert (retire_pc_o == head.pc) else report_mismatch("retire_pc", head.pc, retire_pc_o);
        assert (retire_instr_o == head.instr)
          else report_mismatch("retire_instr", xlen_t'(head.instr), xlen_t'(retire_instr_o));
        assert (retire_rd_o == head.rd)
          else report_mismatch("retire_rd", xlen_t'(head.rd), xlen_t'(retire_rd_o));
        assert (retire_wen_o == head.wen)
          else report_mismatch("retire_wen", xlen_t'(head.wen), xlen_t'(retire_wen_o));
        // data of a non writing slot is don't care
        if (head.wen) begin
          assert (retire_data_o == head.data)
            else report_mismatch("retire_data", head.data, retire_data_o);
          if (head.rd == 5'd10) a0_committed = head.data;
        end
      end else if (exp_q.size() != 0) begin
        assert ($time < exp_q[0].due) else stop_run("an instruction missed its retire cycle");
      end
    end
  end

  initial begin
    void'($urandom(32'h92a5_8742));
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    model_regs    = '{default: '0};
    a0_committed  = '0;
    issue_pc      = `RESET_PC;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    repeat (3) @(negedge clk);
    // idle pipe after reset
    assert (retire_valid_o == 1'b0) else stop_run("retire_valid_o high right after reset");
    assert (reg_a0_o == '0) else report_mismatch("reset_a0", '0, reg_a0_o);
    for (int n = 0; n < NUM_INSTR; n++) begin
      @(posedge clk);
      // occasional bubble
      if ($urandom_range(0, 7) == 0) begin
        instr_valid_i <= 1'b0;
        @(posedge clk);
      end
      issue_random();
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    // let the last a0 write be seen
    repeat (3) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: rv_pipe.f
+incdir+include
src/rv_pipe_pkg.sv
src/pipe_ifs.sv
src/reg_file.sv
src/decode_stage.sv
src/exec_stage.sv
src/rv_pipe_top.sv
test/tb_rv_pipe.sv

// File: run.sh
#!/bin/sh
# builds the testbench with verilator and runs it once
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ns \
  --top-module tb_rv_pipe -f rv_pipe.f -o tb_rv_pipe
sim_out=$(./obj_dir/tb_rv_pipe 2>&1 || true)
echo "$sim_out"
if echo "$sim_out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
